// File: rtl/rv32i_dmem_pkg.sv
// RV32I data memory path
// Shared widths, width codes and word views

`default_nettype none

package rv32i_dmem_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN  = 32;           // Data and address width
    localparam int SEL_W = XLEN / 8;     // Wishbone byte enables, one per lane

    ////////////////////////////////////////////////////////////
    // Core memory control
    ////////////////////////////////////////////////////////////

    // [1:0] access width, [2] unsigned flag for loads
    localparam int MEM_SEL_W = 3;

    localparam logic [1:0] MEM_BYTE = 2'b00;
    localparam logic [1:0] MEM_HALF = 2'b01;
    localparam logic [1:0] MEM_WORD = 2'b10;
    // 2'b11 reserved, treated as misaligned

    // Load control after reset, signed word
    localparam logic [MEM_SEL_W-1:0] MEM_SEL_RESET = {1'b0, MEM_WORD};

    ////////////////////////////////////////////////////////////
    // Word views
    ////////////////////////////////////////////////////////////

    // One bus word, seen as byte lanes or as halfwords
    // Lane 0 is the least significant byte (little endian)
    typedef union packed {
        logic [SEL_W-1:0][7:0] bytes;      // Byte loads, lane writes
        logic [1:0][15:0]      halves;     // Halfword loads
    } dmem_word_u;

endpackage

`default_nettype wire

// File: rtl/wb_if.sv
// Wishbone classic bus

`timescale 1ns/1ps
`default_nettype none

interface wb_if;

    // Request, driven by the master
    logic                             cyc;
    logic                             stb;
    logic                             we;
    logic [rv32i_dmem_pkg::XLEN-1:0]  adr;    // Byte address
    logic [rv32i_dmem_pkg::XLEN-1:0]  dat_w;  // Lane-aligned write data
    logic [rv32i_dmem_pkg::SEL_W-1:0] sel;    // Byte enables

    // Response, driven by the slave
    logic                             stall;
    logic                             ack;
    logic [rv32i_dmem_pkg::XLEN-1:0]  dat_r;
    logic                             err;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        output sel,
        input  stall,
        input  ack,
        input  dat_r,
        input  err
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        input  sel,
        output stall,
        output ack,
        output dat_r,
        output err
    );

endinterface

`default_nettype wire

// File: rtl/rv32i_data_wb_adapter.sv
// Core to Wishbone request stage

`timescale 1ns/1ps
`default_nettype none

module rv32i_data_wb_adapter (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,

    // Core load/store port
    input  wire logic [rv32i_dmem_pkg::XLEN-1:0]      core_addr_i,
    input  wire logic [rv32i_dmem_pkg::XLEN-1:0]      core_data_i,
    input  wire logic                                 core_we_i,
    input  wire logic [rv32i_dmem_pkg::MEM_SEL_W-1:0] core_sel_i,
    output      logic                                 core_err_o,

    // Bus master side
    wb_if.master                                      wb_m,

    // Load control for the load stage, one cycle late
    output      logic [rv32i_dmem_pkg::MEM_SEL_W-1:0] ld_sel_o,
    output      logic [1:0]                           ld_off_o
);

    logic [1:0]                       width;     // Access width code
    logic [1:0]                       off;       // Byte offset in word
    logic [rv32i_dmem_pkg::SEL_W-1:0] base_sel;  // Enables before shift
    logic                             misalign;
    logic [rv32i_dmem_pkg::XLEN-1:0]  st_data;   // Store data in its lanes

    assign width = core_sel_i[1:0];
    assign off   = core_addr_i[1:0];

    ////////////////////////////////////////////////////////////
    // Width decode and alignment check
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (width)
            rv32i_dmem_pkg::MEM_BYTE: begin
                base_sel = 4'b0001;
                misalign = 1'b0;           // Bytes go anywhere
            end
            rv32i_dmem_pkg::MEM_HALF: begin
                base_sel = 4'b0011;
                misalign = off[0];         // Odd address
            end
            rv32i_dmem_pkg::MEM_WORD: begin
                base_sel = 4'b1111;
                misalign = |off;
            end
            default: begin
                base_sel = 4'b0000;        // Reserved code
                misalign = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Store data lane placement
    ////////////////////////////////////////////////////////////

    // Narrow data repeated over all lanes, enables pick the right one
    always_comb begin
        unique case (width)
            rv32i_dmem_pkg::MEM_BYTE: st_data = {4{core_data_i[7:0]}};
            rv32i_dmem_pkg::MEM_HALF: st_data = {2{core_data_i[15:0]}};
            default:                  st_data = core_data_i;
        endcase
    end

    // Bus request, one access per clock
    assign wb_m.cyc   = 1'b1;
    assign wb_m.stb   = 1'b1;
    assign wb_m.we    = core_we_i;
    assign wb_m.adr   = core_addr_i;
    assign wb_m.dat_w = st_data;
    assign wb_m.sel   = misalign ? '0 : base_sel << off;  // Empty mask kills the access

    ////////////////////////////////////////////////////////////
    // Load control, carried into the next cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_sel_o <= rv32i_dmem_pkg::MEM_SEL_RESET;
            ld_off_o <= 2'b00;
        end else begin
            ld_sel_o <= core_sel_i;    // Width and sign for the returned word
            ld_off_o <= off;
        end
    end

    // Registered in the memory, covers misaligned accesses through the empty mask
    assign core_err_o = wb_m.err;

endmodule

`default_nettype wire

// File: rtl/wb_sram.sv
// Wishbone single-port data memory

`timescale 1ns/1ps
`default_nettype none

module wb_sram #(
    parameter int unsigned MEM_DEPTH_WORDS = 256
) (
    input  wire logic clk,
    input  wire logic rst_n,
    wb_if.slave       wb_s
);

    // Word index width, at least one bit
    localparam int IDX_W = (MEM_DEPTH_WORDS > 1) ? $clog2(MEM_DEPTH_WORDS) : 1;

    rv32i_dmem_pkg::dmem_word_u mem [MEM_DEPTH_WORDS];

    rv32i_dmem_pkg::dmem_word_u     wdat;      // Write data by lane
    logic [rv32i_dmem_pkg::XLEN-3:0] word_adr;  // Byte address without offset
    logic [IDX_W-1:0]               idx;
    logic                           acc;       // Bus cycle active
    logic                           in_range;
    logic                           hit;       // Valid access
    logic                           wr_en;

    ////////////////////////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////////////////////////

    assign wdat     = wb_s.dat_w;
    assign word_adr = wb_s.adr[rv32i_dmem_pkg::XLEN-1:2];
    assign idx      = word_adr[IDX_W-1:0];
    assign in_range = {2'b00, word_adr} < MEM_DEPTH_WORDS;
    assign acc      = wb_s.cyc & wb_s.stb;
    assign hit      = acc & in_range & (|wb_s.sel);  // Empty mask is an error
    assign wr_en    = hit & wb_s.we;

    // Never stalls
    assign wb_s.stall = 1'b0;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    // Only enabled lanes change
    always_ff @(posedge clk) begin
        for (int i = 0; i < rv32i_dmem_pkg::SEL_W; i++) begin
            if (wr_en && wb_s.sel[i]) begin
                mem[idx].bytes[i] <= wdat.bytes[i];
            end
        end
    end

    // Read data, old contents on a write to the same word
    always_ff @(posedge clk) begin
        if (hit) begin
            wb_s.dat_r <= mem[idx];
        end else begin
            wb_s.dat_r <= '0;          // Error read value
        end
    end

    ////////////////////////////////////////////////////////////
    // Response flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_s.ack <= 1'b0;
            wb_s.err <= 1'b0;
        end else begin
            wb_s.ack <= acc;           // Every access acknowledged next cycle
            wb_s.err <= acc & ~hit;    // Out of range or no lanes
        end
    end

endmodule

`default_nettype wire

// File: rtl/data_organizer.sv
// Load data select and extend

`timescale 1ns/1ps
`default_nettype none

module data_organizer (
    input  wire logic [rv32i_dmem_pkg::XLEN-1:0]      data_i,  // Word from the bus
    input  wire logic [rv32i_dmem_pkg::MEM_SEL_W-1:0] sel_i,   // Width and unsigned flag
    input  wire logic [1:0]                           off_i,   // Byte offset of the load
    output      logic [rv32i_dmem_pkg::XLEN-1:0]      data_o
);

    rv32i_dmem_pkg::dmem_word_u word;
    logic [7:0]                 ld_byte;
    logic [15:0]                ld_half;
    logic                       is_unsigned;
    logic                       byte_fill;   // Extension bit for bytes
    logic                       half_fill;   // Extension bit for halfwords

    assign word        = data_i;
    assign is_unsigned = sel_i[2];

    ////////////////////////////////////////////////////////////
    // Lane select
    ////////////////////////////////////////////////////////////

    assign ld_byte = word.bytes[off_i];
    assign ld_half = word.halves[off_i[1]];  // Offset bit 0 is zero when aligned

    // Sign bit or zero
    assign byte_fill = ~is_unsigned & ld_byte[7];
    assign half_fill = ~is_unsigned & ld_half[15];

    ////////////////////////////////////////////////////////////
    // Extend to full width
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (sel_i[1:0])
            rv32i_dmem_pkg::MEM_BYTE: begin
                data_o = {{(rv32i_dmem_pkg::XLEN-8){byte_fill}}, ld_byte};
            end
            rv32i_dmem_pkg::MEM_HALF: begin
                data_o = {{(rv32i_dmem_pkg::XLEN-16){half_fill}}, ld_half};
            end
            default: begin
                // Word, or reserved code with the zero error word
                data_o = data_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv32i_dmem_top.sv
// RV32I data memory path top

`timescale 1ns/1ps
`default_nettype none

module rv32i_dmem_top #(
    parameter int unsigned MEM_DEPTH_WORDS = 256   // Memory size in words
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,

    // Core load/store port
    input  wire logic [rv32i_dmem_pkg::XLEN-1:0]      core_addr_i,
    input  wire logic [rv32i_dmem_pkg::XLEN-1:0]      core_data_i,
    input  wire logic                                 core_we_i,
    input  wire logic [rv32i_dmem_pkg::MEM_SEL_W-1:0] core_sel_i,
    output      logic [rv32i_dmem_pkg::XLEN-1:0]      core_data_o,
    output      logic                                 core_err_o
);

    wb_if wb_bus ();

    logic [rv32i_dmem_pkg::MEM_SEL_W-1:0] ld_sel;  // Load control, next cycle
    logic [1:0]                           ld_off;  // Byte offset, next cycle

    // Request stage
    rv32i_data_wb_adapter i_adapter (
        .clk         (clk),
        .rst_n       (rst_n),
        .core_addr_i (core_addr_i),
        .core_data_i (core_data_i),
        .core_we_i   (core_we_i),
        .core_sel_i  (core_sel_i),
        .core_err_o  (core_err_o),
        .wb_m        (wb_bus.master),
        .ld_sel_o    (ld_sel),
        .ld_off_o    (ld_off)
    );

    // Memory stage
    wb_sram #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
    ) i_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_s  (wb_bus.slave)
    );

    // Load stage
    data_organizer i_organizer (
        .data_i (wb_bus.dat_r),
        .sel_i  (ld_sel),
        .off_i  (ld_off),
        .data_o (core_data_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_clkgen.sv
// Testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int CLK_PERIOD = 8,    // ns
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;              // Reset from time zero
    end

    always #(CLK_PERIOD / 2.0) clk_o = ~clk_o;

    // Release on a rising edge
    initial begin
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/rv32i_dmem_assert.sv
// Bus and error protocol assertions

`timescale 1ns/1ps
`default_nettype none

module rv32i_dmem_assert (
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       ack_i,       // Bus acknowledge
    input wire logic [3:0] sel_i,       // Bus byte enables
    input wire logic       stall_i,
    input wire logic       core_err_i
);

    // Every cycle out of reset is an access, so ack follows
    ack_follows: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> ack_i)
        else $error("Bus acknowledge missing after an access");

    // Empty, or one byte, an aligned halfword or the full word
    sel_shape: assert property (@(posedge clk)
        sel_i inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                      4'b0011, 4'b1100, 4'b1111})
        else $error("Byte enables not a contiguous aligned mask: %b", sel_i);

    // Memory never back-pressures
    no_stall: assert property (@(posedge clk) !stall_i)
        else $error("Bus stall raised");

    // First cycle after reset release
    err_quiet: assert property (@(posedge clk)
        (rst_n && !$past(rst_n)) |-> !core_err_i)
        else $error("Error flag high in the first cycle after reset");

endmodule

bind rv32i_dmem_top rv32i_dmem_assert i_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .ack_i      (wb_bus.ack),
    .sel_i      (wb_bus.sel),
    .stall_i    (wb_bus.stall),
    .core_err_i (core_err_o)
);

`default_nettype wire

// File: tests/rv32i_dmem_tb.sv
// Data memory path testbench

`timescale 1ns/1ps
`default_nettype none

module rv32i_dmem_tb;

    localparam int          MEM_WORDS  = 256;
    localparam int          CLK_PERIOD = 8;
    localparam int          RST_CYCLES = 4;
    localparam int          FILL_WORDS = 16;     // Words defined before any load
    localparam int          RAND_OPS   = 32;
    localparam logic [31:0] SEED       = 32'ha1d3_7a77;

    // Width and sign codes, bit 2 unsigned
    localparam logic [2:0] LB  = 3'b000;
    localparam logic [2:0] LH  = 3'b001;
    localparam logic [2:0] LW  = 3'b010;
    localparam logic [2:0] RSV = 3'b011;
    localparam logic [2:0] LBU = 3'b100;
    localparam logic [2:0] LHU = 3'b101;

    typedef struct {
        logic        we;
        logic [31:0] addr;
        logic [2:0]  sel;
        logic [31:0] wdata;
        logic [31:0] exp_data;   // Loads only
        logic        exp_err;
    } access_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] core_addr;
    logic [31:0] core_wdata;
    logic        core_we;
    logic [2:0]  core_sel;
    logic [31:0] core_rdata;
    logic        core_err;

    logic [7:0]  model_mem [MEM_WORDS*4];   // Byte-wide reference memory
    access_t     acc_q [$];                 // Stimulus and expected values
    bit          table_ready;

    tb_clkgen #(.CLK_PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) i_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv32i_dmem_top #(.MEM_DEPTH_WORDS(MEM_WORDS)) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .core_addr_i (core_addr),
        .core_data_i (core_wdata),
        .core_we_i   (core_we),
        .core_sel_i  (core_sel),
        .core_data_o (core_rdata),
        .core_err_o  (core_err)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic access_error(input logic [31:0] addr, input logic [2:0] sel);
        logic misaligned;
        case (sel[1:0])
            2'b00:   misaligned = 1'b0;
            2'b01:   misaligned = addr[0];               // Odd halfword
            2'b10:   misaligned = (addr[1:0] != 2'b00);
            default: misaligned = 1'b1;                  // Reserved width
        endcase
        return misaligned || (addr[31:2] >= MEM_WORDS);
    endfunction

    // Predict one access, then apply it to the model
    task automatic add_access(input logic we, input logic [31:0] addr,
                              input logic [2:0] sel, input logic [31:0] wdata);
        access_t     a;
        int          nbytes;
        logic [31:0] raw;
        a.we       = we;
        a.addr     = addr;
        a.sel      = sel;
        a.wdata    = wdata;
        a.exp_err  = access_error(addr, sel);
        a.exp_data = '0;                           // Error loads return zero
        raw        = '0;
        nbytes     = 1 << sel[1:0];
        if (!a.exp_err) begin
            for (int b = 0; b < nbytes; b++) begin
                raw[8*b +: 8] = model_mem[addr + b];
                if (we) model_mem[addr + b] = wdata[8*b +: 8];
            end
            case (sel[1:0])
                2'b00:   a.exp_data = sel[2] ? {24'h0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
                2'b01:   a.exp_data = sel[2] ? {16'h0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
                default: a.exp_data = raw;
            endcase
        end
        acc_q.push_back(a);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        logic [31:0] addr;
        logic [2:0]  sel;
        for (int w = 0; w < FILL_WORDS; w++) add_access(1'b1, w * 4, LW, $urandom);
        // Word store, load right after and after a gap
        add_access(1'b1, 32'h20, LW, 32'hdead_beef);
        add_access(1'b0, 32'h20, LW, '0);
        add_access(1'b1, 32'h24, LW, 32'h8765_4321);
        add_access(1'b0, 32'h28, LW, '0);
        add_access(1'b0, 32'h24, LW, '0);
        // Byte lanes, upper store bits are noise
        add_access(1'b1, 32'h30, LB, 32'h1234_5681);
        add_access(1'b1, 32'h31, LB, 32'hffff_ff7f);
        add_access(1'b1, 32'h32, LB, 32'h0000_00c3);
        add_access(1'b1, 32'h33, LB, 32'haaaa_aa05);
        add_access(1'b0, 32'h30, LW, '0);
        for (int o = 0; o < 4; o++) begin
            add_access(1'b0, 32'h30 + o, LB, '0);
            add_access(1'b0, 32'h30 + o, LBU, '0);
        end
        // Halfwords at offsets 0 and 2
        add_access(1'b1, 32'h34, LH, 32'hffff_8001);
        add_access(1'b1, 32'h36, LH, 32'h0000_7ffe);
        add_access(1'b0, 32'h34, LW, '0);
        add_access(1'b0, 32'h34, LH, '0);
        add_access(1'b0, 32'h34, LHU, '0);
        add_access(1'b0, 32'h36, LH, '0);
        add_access(1'b0, 32'h36, LHU, '0);
        // Misaligned and reserved, stores must not land
        add_access(1'b1, 32'h39, LH, 32'h0000_ffff);
        add_access(1'b1, 32'h3a, LW, 32'hffff_ffff);
        add_access(1'b1, 32'h38, RSV, 32'h5555_5555);
        add_access(1'b0, 32'h38, LW, '0);
        add_access(1'b0, 32'h3b, LHU, '0);
        add_access(1'b0, 32'h3d, LW, '0);
        add_access(1'b0, 32'h38, 3'b111, '0);
        // Beyond the last word
        add_access(1'b1, MEM_WORDS * 4, LW, 32'h0bad_0bad);
        add_access(1'b0, MEM_WORDS * 4, LW, '0);
        add_access(1'b0, 32'h0000_07ff, LBU, '0);
        add_access(1'b0, 32'hffff_fffc, LW, '0);
        // Store then load of the same word, no gaps
        for (int k = 0; k < 8; k++) begin
            add_access(1'b1, 32'h10 + k, LB, $urandom);
            add_access(1'b0, 32'h10 + (k & ~1), (k % 2) ? LH : LHU, '0);
        end
        // Random mix inside the defined words
        for (int k = 0; k < RAND_OPS; k++) begin
            addr = ($urandom_range(FILL_WORDS - 1) << 2) | $urandom_range(3);
            sel  = $urandom_range(7);
            add_access($urandom_range(1), addr, sel, $urandom);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, why);
    endtask

    task automatic drive_access(input access_t a);
        core_we    <= a.we;
        core_addr  <= a.addr;
        core_sel   <= a.sel;
        core_wdata <= a.wdata;
    endtask

    task automatic check_result(input access_t a, input int idx);
        assert (core_err === a.exp_err) else begin
            $display("[ERROR] core_err_o: expected %h, got %h (access %0d, addr %h)",
                     a.exp_err, core_err, idx, a.addr);
            abort_run("error flag mismatch");
        end
        if (!a.we) begin
            assert (core_rdata === a.exp_data) else begin
                $display("[ERROR] core_data_o: expected %h, got %h (access %0d, addr %h)",
                         a.exp_data, core_rdata, idx, a.addr);
                abort_run("load data mismatch");
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        core_we    = 1'b0;
        core_addr  = '0;
        core_sel   = LW;
        core_wdata = '0;
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        // Result of access i is read in the cycle after it
        for (int i = 0; i <= acc_q.size(); i++) begin
            @(posedge clk);
            if (i < acc_q.size()) drive_access(acc_q[i]);
            else drive_access('{1'b0, 32'h0, LW, 32'h0, 32'h0, 1'b0});   // Idle read
            @(negedge clk);
            if (i > 0) check_result(acc_q[i-1], i - 1);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

    // Table length plus reset and a margin
    initial begin : watchdog
        wait (table_ready);
        #((acc_q.size() + RST_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the access table did not complete in the expected time");
        abort_run("watchdog expired");
    end

endmodule

`default_nettype wire

// File: rv32i_dmem_top.f
rtl/rv32i_dmem_pkg.sv
rtl/wb_if.sv
rtl/rv32i_data_wb_adapter.sv
rtl/wb_sram.sv
rtl/data_organizer.sv
rtl/rv32i_dmem_top.sv
tests/tb_clkgen.sv
tests/rv32i_dmem_assert.sv
tests/rv32i_dmem_tb.sv

// File: Bender.yml
package:
  name: rv32i_dmem

sources:
  # Design, package first
  - rtl/rv32i_dmem_pkg.sv
  - rtl/wb_if.sv
  - rtl/rv32i_data_wb_adapter.sv
  - rtl/wb_sram.sv
  - rtl/data_organizer.sv
  - rtl/rv32i_dmem_top.sv

  # Testbench
  - target: test
    files:
      - tests/tb_clkgen.sv
      - tests/rv32i_dmem_assert.sv
      - tests/rv32i_dmem_tb.sv
